// ==== Bender.yml ====
package:
  name: gfx_tile

sources:
  - design/gfx_pkg.sv
  - design/gfx_dpram.sv
  - design/video_timer.sv
  - design/gfx_cpu_port.sv
  - design/tile_fetch.sv
  - design/gfx_mixer.sv
  - design/gfx_top.sv
  - target: test
    files:
      - dv/gfx_checker.sv
      - dv/gfx_monitor.sv
      - dv/gfx_tb.sv

// ==== design/gfx_cpu_port.sv ====
/*
  Wishbone classic slave for the layer registers and the tile-code VRAM.
  ack comes two cycles after cyc and stb are first seen and lasts one cycle.
  The master must hold the request until ack. Writes commit at the end of the ack cycle.
  adr[10] selects VRAM, otherwise adr[1:0] picks one of four byte registers.
*/
`timescale 1ns/1ps
`default_nettype none

module gfx_cpu_port
    import gfx_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  wb_req_t            wb_i,
    output wb_rsp_t            wb_o,
    input  logic [VRAM_AW-1:0] vram_addr,
    output logic [7:0]         vram_code,
    output scroll_cfg_t        scroll,
    output mix_cfg_t           mix
);

    logic       req;
    logic       sel_vram;
    logic       pend;
    logic       ack;
    logic       wr_commit;
    logic [7:0] dat_r;
    logic [7:0] reg_rd;
    logic [7:0] vram_q;
    logic [7:0] hscroll_r;
    logic [7:0] vscroll_r;
    logic [7:0] ctrl_r;
    logic [7:0] backdrop_r;

    assign req       = wb_i.cyc & wb_i.stb;
    assign sel_vram  = wb_i.adr[VRAM_AW];
    assign wr_commit = ack & wb_i.we;

    always_comb begin
        case (wb_i.adr[1:0])
            REG_HSCROLL: reg_rd = hscroll_r;
            REG_VSCROLL: reg_rd = vscroll_r;
            REG_CTRL:    reg_rd = ctrl_r;
            default:     reg_rd = backdrop_r;
        endcase
    end

    // First cycle waits for the VRAM read, second one acks
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pend <= 1'b0;
            ack  <= 1'b0;
        end else begin
            pend <= req & ~pend & ~ack;
            ack  <= pend & req;
        end
    end

    always_ff @(posedge clk) begin
        if (pend) begin
            dat_r <= sel_vram ? vram_q : reg_rd;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hscroll_r  <= '0;
            vscroll_r  <= '0;
            ctrl_r     <= '0;
            backdrop_r <= '0;
        end else if (wr_commit && !sel_vram) begin
            case (wb_i.adr[1:0])
                REG_HSCROLL: hscroll_r  <= wb_i.dat_w;
                REG_VSCROLL: vscroll_r  <= wb_i.dat_w;
                REG_CTRL:    ctrl_r     <= wb_i.dat_w;
                default:     backdrop_r <= wb_i.dat_w;
            endcase
        end
    end

    assign wb_o = '{ack: ack, dat_r: dat_r};

    assign scroll = '{hscroll: hscroll_r, vscroll: vscroll_r};
    // Backdrop bit 7 is kept only for read back
    assign mix = '{
        irq_en:   ctrl_r[CTRL_IRQ_EN],
        pal_bank: ctrl_r[CTRL_PAL_LSB +: 2],
        backdrop: backdrop_r[6:0]
    };

    // Port b belongs to the tile fetcher
    gfx_dpram #(
        .T  (logic [7:0]),
        .AW (VRAM_AW)
    ) u_vram (
        .clk    (clk),
        .we_a   (wr_commit & sel_vram),
        .addr_a (wb_i.adr[VRAM_AW-1:0]),
        .d_a    (wb_i.dat_w),
        .q_a    (vram_q),
        .addr_b (vram_addr),
        .q_b    (vram_code)
    );

endmodule

`default_nettype wire

// ==== design/gfx_dpram.sv ====
/*
  Simple dual-port RAM, one clock. Port a reads and writes, port b only reads.
  Both outputs are registered; port a returns the old word on a write.
  No reset, contents are undefined until written.
*/
`timescale 1ns/1ps
`default_nettype none

module gfx_dpram #(
    parameter type T  = logic [7:0],
    parameter int  AW = 8
) (
    input  logic          clk,
    input  logic          we_a,
    input  logic [AW-1:0] addr_a,
    input  T              d_a,
    output T              q_a,
    input  logic [AW-1:0] addr_b,
    output T              q_b
);

    T mem [2**AW];

    always_ff @(posedge clk) begin
        if (we_a) begin
            mem[addr_a] <= d_a;
        end
        q_a <= mem[addr_a];
        q_b <= mem[addr_b];
    end

endmodule

`default_nettype wire

// ==== design/gfx_mixer.sv ====
/*
  Colour output and vertical blank interrupt.
  Reads the line-buffer half for vdump parity. pxl_out lags the raster by 2 clocks.
  irq is set on the first line of vertical blanking and cleared after the next line_start.
*/
`timescale 1ns/1ps
`default_nettype none

module gfx_mixer
    import gfx_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  video_pos_t       pos,
    input  mix_cfg_t         cfg,
    output logic [LINE_AW:0] lb_addr,
    input  tile_pix_t        lb_q,
    output logic [6:0]       pxl_out,
    output logic             irq
);

    logic vis_d;
    logic lvbl_d;
    logic vb_start;

    assign lb_addr = {pos.vdump[0], pos.hdump[LINE_AW-1:0]};

    // Blank flag delayed to line up with the buffer read
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vis_d   <= 1'b0;
            pxl_out <= '0;
        end else begin
            vis_d <= pos.lhbl & pos.lvbl;
            if (!vis_d) begin
                pxl_out <= '0;
            end else if (lb_q == 4'd0) begin
                pxl_out <= cfg.backdrop;
            end else begin
                pxl_out <= {cfg.pal_bank, 1'b1, lb_q};
            end
        end
    end

    assign vb_start = ~pos.lvbl & lvbl_d;

    // Blanking starts on a line_start, so setting wins over clearing
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lvbl_d <= 1'b0;
            irq    <= 1'b0;
        end else begin
            lvbl_d <= pos.lvbl;
            if (vb_start && cfg.irq_en) begin
                irq <= 1'b1;
            end else if (pos.line_start) begin
                irq <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/gfx_pkg.sv ====
/*
  Shared types, widths and the register map of the tile layer.
  The map is 32x32 tile codes and a line-buffer half holds at most 512 pixels.
  REG_CTRL: bit 0 enables the vertical blank interrupt, bits 5:4 select the palette bank.
*/
`default_nettype none

package gfx_pkg;

    localparam int VRAM_AW = 10;
    localparam int LINE_AW = 9;
    localparam int ROM_AW  = 12;
    localparam int WB_AW   = VRAM_AW + 1;

    // Register addresses, used when adr[10] is clear
    localparam logic [1:0] REG_HSCROLL  = 2'd0;
    localparam logic [1:0] REG_VSCROLL  = 2'd1;
    localparam logic [1:0] REG_CTRL     = 2'd2;
    localparam logic [1:0] REG_BACKDROP = 2'd3;

    localparam int CTRL_IRQ_EN  = 0;
    localparam int CTRL_PAL_LSB = 4;

    typedef struct packed {
        logic [8:0] hdump;
        logic [8:0] vdump;
        logic [8:0] vrender;
        logic       lhbl;
        logic       lvbl;
        logic       line_start;
    } video_pos_t;

    typedef struct packed {
        logic             cyc;
        logic             stb;
        logic             we;
        logic [WB_AW-1:0] adr;
        logic [7:0]       dat_w;
    } wb_req_t;

    typedef struct packed {
        logic       ack;
        logic [7:0] dat_r;
    } wb_rsp_t;

    typedef struct packed {
        logic              cs;
        logic [ROM_AW-1:0] addr;
    } rom_req_t;

    typedef struct packed {
        logic [7:0] hscroll;
        logic [7:0] vscroll;
    } scroll_cfg_t;

    typedef struct packed {
        logic       irq_en;
        logic [1:0] pal_bank;
        logic [6:0] backdrop;
    } mix_cfg_t;

    // Colour index 0 is transparent
    typedef logic [3:0] tile_pix_t;

endpackage

`default_nettype wire

// ==== design/gfx_top.sv ====
/*
  Tile layer top level with a single clock, one pixel per clock.
  pxl_out for a raster position comes 2 clocks after that position on hdump/vdump.
  The ROM must finish a line of fetches within H_TOTAL clocks.
  H_VIS up to 512, all totals below 512.
*/
`timescale 1ns/1ps
`default_nettype none

module gfx_top
    import gfx_pkg::*;
#(
    parameter int H_VIS   = 256,
    parameter int H_TOTAL = 384,
    parameter int V_VIS   = 224,
    parameter int V_TOTAL = 264
) (
    input  logic        clk,
    input  logic        rst,
    input  wb_req_t     wb_i,
    output wb_rsp_t     wb_o,
    output rom_req_t    rom,
    input  logic [15:0] rom_data,
    input  logic        rom_ok,
    output logic [8:0]  hdump,
    output logic [8:0]  vdump,
    output logic        lhbl,
    output logic        lvbl,
    output logic [6:0]  pxl_out,
    output logic        irq
);

    video_pos_t         pos;
    scroll_cfg_t        scroll;
    mix_cfg_t           mix;
    logic [VRAM_AW-1:0] vram_addr;
    logic [7:0]         vram_code;
    logic               lb_we;
    logic [LINE_AW:0]   lb_waddr;
    logic [LINE_AW:0]   lb_raddr;
    tile_pix_t          lb_d;
    tile_pix_t          lb_q;

    assign hdump = pos.hdump;
    assign vdump = pos.vdump;
    assign lhbl  = pos.lhbl;
    assign lvbl  = pos.lvbl;

    video_timer #(
        .H_VIS   (H_VIS),
        .H_TOTAL (H_TOTAL),
        .V_VIS   (V_VIS),
        .V_TOTAL (V_TOTAL)
    ) u_timer (
        .clk (clk),
        .rst (rst),
        .pos (pos)
    );

    gfx_cpu_port u_cpu_port (
        .clk       (clk),
        .rst       (rst),
        .wb_i      (wb_i),
        .wb_o      (wb_o),
        .vram_addr (vram_addr),
        .vram_code (vram_code),
        .scroll    (scroll),
        .mix       (mix)
    );

    tile_fetch #(
        .H_VIS (H_VIS)
    ) u_fetch (
        .clk       (clk),
        .rst       (rst),
        .pos       (pos),
        .scroll    (scroll),
        .vram_addr (vram_addr),
        .vram_code (vram_code),
        .rom       (rom),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .lb_we     (lb_we),
        .lb_addr   (lb_waddr),
        .lb_d      (lb_d)
    );

    // Two halves, one being drawn while the other is shown
    gfx_dpram #(
        .T  (tile_pix_t),
        .AW (LINE_AW + 1)
    ) u_line_buf (
        .clk    (clk),
        .we_a   (lb_we),
        .addr_a (lb_waddr),
        .d_a    (lb_d),
        .q_a    (),
        .addr_b (lb_raddr),
        .q_b    (lb_q)
    );

    gfx_mixer u_mixer (
        .clk     (clk),
        .rst     (rst),
        .pos     (pos),
        .cfg     (mix),
        .lb_addr (lb_raddr),
        .lb_q    (lb_q),
        .pxl_out (pxl_out),
        .irq     (irq)
    );

endmodule

`default_nettype wire

// ==== design/tile_fetch.sv ====
/*
  Line renderer for the tile layer. Starts at line_start and draws vrender
  into line-buffer half vrender[0]. Fetches H_VIS/8+1 tiles so fine scroll is covered.
  ROM words hold four pixels, leftmost in the low nibble. Each tile takes two words.
  The whole line must finish within H_TOTAL clocks, which depends on ROM latency.
*/
`timescale 1ns/1ps
`default_nettype none

module tile_fetch
    import gfx_pkg::*;
#(
    parameter int H_VIS = 256
) (
    input  logic               clk,
    input  logic               rst,
    input  video_pos_t         pos,
    input  scroll_cfg_t        scroll,
    output logic [VRAM_AW-1:0] vram_addr,
    input  logic [7:0]         vram_code,
    output rom_req_t           rom,
    input  logic [15:0]        rom_data,
    input  logic               rom_ok,
    output logic               lb_we,
    output logic [LINE_AW:0]   lb_addr,
    output tile_pix_t          lb_d
);

    localparam int NTILE = H_VIS / 8 + 1;
    localparam int TW    = $clog2(NTILE + 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_MAP,
        S_REQ,
        S_WAIT,
        S_UNPACK
    } state_t;

    state_t            state;
    logic [4:0]        col;
    logic [TW-1:0]     tile_cnt;
    logic [9:0]        x;
    logic [1:0]        pix_cnt;
    logic              half;
    logic              rom_cs;
    logic [ROM_AW-1:0] rom_addr;
    logic [15:0]       pix_r;
    logic [7:0]        src_row;
    logic              line_half;
    logic              busy;
    logic              render_line;
    logic              start_fetch;
    logic              last_tile;

    assign busy = state != S_IDLE;
    // Lines 0 to V_VIS get drawn, the extra one only ever shows in blanking
    assign render_line = pos.lvbl | (pos.vrender == 9'd0);
    assign start_fetch = pos.line_start & render_line & ~busy;
    assign last_tile   = tile_cnt == TW'(NTILE - 1);

    // Map is 32 columns wide, col wraps on its own
    assign vram_addr = {src_row[7:3], col};
    assign rom       = '{cs: rom_cs, addr: rom_addr};

    // x below zero shows up as a large unsigned value and is clipped too
    assign lb_we   = (state == S_UNPACK) && (x < 10'(H_VIS));
    assign lb_addr = {line_half, x[LINE_AW-1:0]};
    assign lb_d    = pix_r[{pix_cnt, 2'b00} +: 4];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= S_IDLE;
            col      <= '0;
            tile_cnt <= '0;
            x        <= '0;
            pix_cnt  <= '0;
            half     <= 1'b0;
            rom_cs   <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start_fetch) begin
                        col      <= scroll.hscroll[7:3];
                        tile_cnt <= '0;
                        // Fine scroll pushes the first tile left of the screen
                        x        <= 10'd0 - 10'(scroll.hscroll[2:0]);
                        state    <= S_MAP;
                    end
                end
                // VRAM read takes one cycle
                S_MAP: state <= S_REQ;
                S_REQ: begin
                    rom_cs <= 1'b1;
                    half   <= 1'b0;
                    state  <= S_WAIT;
                end
                S_WAIT: begin
                    if (rom_ok) begin
                        rom_cs  <= 1'b0;
                        pix_cnt <= '0;
                        state   <= S_UNPACK;
                    end
                end
                S_UNPACK: begin
                    x       <= x + 10'd1;
                    pix_cnt <= pix_cnt + 2'd1;
                    if (pix_cnt == 2'd3) begin
                        if (!half) begin
                            // Right half of the same tile row
                            half   <= 1'b1;
                            rom_cs <= 1'b1;
                            state  <= S_WAIT;
                        end else if (last_tile) begin
                            state <= S_IDLE;
                        end else begin
                            col      <= col + 5'd1;
                            tile_cnt <= tile_cnt + TW'(1);
                            state    <= S_MAP;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_fetch) begin
            src_row   <= pos.vrender[7:0] + scroll.vscroll;
            line_half <= pos.vrender[0];
        end
        if (state == S_REQ) begin
            rom_addr <= {vram_code, src_row[2:0], 1'b0};
        end
        if (state == S_WAIT && rom_ok) begin
            pix_r <= rom_data;
        end
        if (state == S_UNPACK && pix_cnt == 2'd3 && !half) begin
            rom_addr[0] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== design/video_timer.sv ====
/*
  Raster counters. One pixel per clock, no separate pixel enable.
  Visible area starts at hdump 0 and vdump 0, all totals must fit in 9 bits.
  vrender runs one line ahead of vdump and wraps at V_TOTAL.
*/
`timescale 1ns/1ps
`default_nettype none

module video_timer
    import gfx_pkg::*;
#(
    parameter int H_VIS   = 256,
    parameter int H_TOTAL = 384,
    parameter int V_VIS   = 224,
    parameter int V_TOTAL = 264
) (
    input  logic       clk,
    input  logic       rst,
    output video_pos_t pos
);

    logic [8:0] hcnt;
    logic [8:0] vcnt;
    logic       h_last;
    logic       v_last;

    assign h_last = hcnt == 9'(H_TOTAL - 1);
    assign v_last = vcnt == 9'(V_TOTAL - 1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hcnt <= '0;
            vcnt <= '0;
        end else begin
            if (h_last) begin
                hcnt <= '0;
                vcnt <= v_last ? 9'd0 : vcnt + 9'd1;
            end else begin
                hcnt <= hcnt + 9'd1;
            end
        end
    end

    always_comb begin
        pos.hdump      = hcnt;
        pos.vdump      = vcnt;
        // Line being fetched for display on the next line
        pos.vrender    = v_last ? 9'd0 : vcnt + 9'd1;
        pos.lhbl       = hcnt < 9'(H_VIS);
        pos.lvbl       = vcnt < 9'(V_VIS);
        pos.line_start = hcnt == 9'd0;
    end

endmodule

`default_nettype wire

// ==== dv/gfx_checker.sv ====
/*
  Protocol assertions, bound into tile_fetch and gfx_cpu_port.
  Unused inputs of an instance are tied off in its bind.
  The fetch deadline holds only while the ROM answers within 4 cycles.
  fail_cnt counts failed assertions for the testbench summary.
*/
`timescale 1ns/1ps
`default_nettype none

module gfx_checker
    import gfx_pkg::*;
(
    input logic              clk,
    input logic              rst,
    input logic              ack,
    input logic              rom_cs,
    input logic [ROM_AW-1:0] rom_addr,
    input logic              rom_ok,
    input logic              busy,
    input logic              line_start
);

    int fail_cnt = 0;

    ack_one_cycle: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
        else begin
            fail_cnt++;
            $error("ack held for more than one cycle");
        end

    // Address must hold until the grant
    rom_addr_stable: assert property (@(posedge clk) disable iff (rst)
        rom_cs && !rom_ok |=> $stable(rom_addr) && rom_cs)
        else begin
            fail_cnt++;
            $error("ROM request changed before rom_ok");
        end

    rom_cs_drop: assert property (@(posedge clk) disable iff (rst)
        rom_cs && rom_ok |=> !rom_cs)
        else begin
            fail_cnt++;
            $error("ROM cs still high after the grant");
        end

    fetch_deadline: assert property (@(posedge clk) disable iff (rst) line_start |-> !busy)
        else begin
            fail_cnt++;
            $error("tile fetcher still busy at line start");
        end

endmodule

bind tile_fetch gfx_checker u_fetch_chk (
    .clk        (clk),
    .rst        (rst),
    .ack        (1'b0),
    .rom_cs     (rom.cs),
    .rom_addr   (rom.addr),
    .rom_ok     (rom_ok),
    .busy       (busy),
    .line_start (pos.line_start)
);

bind gfx_cpu_port gfx_checker u_port_chk (
    .clk        (clk),
    .rst        (rst),
    .ack        (wb_o.ack),
    .rom_cs     (1'b0),
    .rom_addr   ('0),
    .rom_ok     (1'b0),
    .busy       (1'b0),
    .line_start (1'b0)
);

`default_nettype wire

// ==== dv/gfx_monitor.sv ====
/*
  Reference model and comparator for the tile layer.
  Keeps its own VRAM and register copy from snooped Wishbone writes.
  Pixels are checked from the first frame start after check_en rises,
  so VRAM and scroll must not change after that.
*/
`timescale 1ns/1ps
`default_nettype none

module gfx_monitor
    import gfx_pkg::*;
#(
    parameter int H_VIS   = 256,
    parameter int H_TOTAL = 384,
    parameter int V_VIS   = 224,
    parameter int V_TOTAL = 264
) (
    input  logic       clk,
    input  logic       rst,
    input  wb_req_t    wb_i,
    input  wb_rsp_t    wb_o,
    input  rom_req_t   rom,
    input  logic [8:0] hdump,
    input  logic [8:0] vdump,
    input  logic       lhbl,
    input  logic       lvbl,
    input  logic [6:0] pxl_out,
    input  logic       irq,
    input  logic       check_en,
    input  logic [7:0] exp_dat,
    output int         errors,
    output int         pix_count
);

    logic [7:0] vram_m [2**VRAM_AW];
    logic [7:0] regs_m [4];
    logic [8:0] h_d1;
    logic [8:0] v_d1;
    logic [8:0] h_d2;
    logic [8:0] v_d2;
    logic [7:0] model_rd;
    int         age;
    int         req_cnt;
    int         h_exp;
    int         v_exp;
    bit         armed;
    bit         irq_exp;

    // ROM contents, also used by the ROM model in the testbench
    function automatic logic [15:0] rom_word(input logic [ROM_AW-1:0] a);
        return (16'(a) * 16'h9e37) ^ {4'h0, a};
    endfunction

    function automatic logic [6:0] exp_pixel(input logic [8:0] h, input logic [8:0] v);
        logic [7:0]  row;
        logic [9:0]  sx;
        logic [7:0]  code;
        logic [15:0] word;
        logic [3:0]  pix;
        if (h >= H_VIS || v >= V_VIS) begin
            return 7'd0;
        end
        row  = v[7:0] + regs_m[REG_VSCROLL];
        sx   = 10'(h) + 10'(regs_m[REG_HSCROLL]);
        code = vram_m[{row[7:3], sx[7:3]}];
        word = rom_word({code, row[2:0], sx[2]});
        pix  = word[{sx[1:0], 2'b00} +: 4];
        if (pix == 4'd0) begin
            return regs_m[REG_BACKDROP][6:0];
        end
        return {regs_m[REG_CTRL][5:4], 1'b1, pix};
    endfunction

    task automatic check_val(input string name, input logic [15:0] exp, input logic [15:0] got);
        if (got !== exp) begin
            errors++;
            $display("error %0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    initial begin
        errors    = 0;
        pix_count = 0;
    end

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            age     = 0;
            req_cnt = 0;
            h_exp   = 0;
            v_exp   = 0;
            armed   = 0;
            irq_exp = 0;
            h_d1    = '0;
            v_d1    = '0;
            h_d2    = '0;
            v_d2    = '0;
        end else begin
            // Outputs stay quiet right after reset
            // Pixel (0,0) is visible and reaches pxl_out from the third edge on
            if (age < 2) begin
                check_val("pxl_out", 16'd0, 16'(pxl_out));
            end
            if (age < 3) begin
                check_val("ack", 16'd0, 16'(wb_o.ack));
                check_val("rom_cs", 16'd0, 16'(rom.cs));
            end
            // Raster position and blanking flags
            check_val("hdump", 16'(h_exp), 16'(hdump));
            check_val("vdump", 16'(v_exp), 16'(vdump));
            check_val("lhbl", 16'(h_exp < H_VIS), 16'(lhbl));
            check_val("lvbl", 16'(v_exp < V_VIS), 16'(lvbl));
            if (h_exp == H_TOTAL - 1) begin
                h_exp = 0;
                v_exp = (v_exp == V_TOTAL - 1) ? 0 : v_exp + 1;
            end else begin
                h_exp++;
            end
            if (check_en && age >= 2 && h_d2 == 9'd0 && v_d2 == 9'd0) begin
                armed = 1;
            end
            if (armed) begin
                check_val("pxl_out", 16'(exp_pixel(h_d2, v_d2)), 16'(pxl_out));
                pix_count++;
            end
            check_val("irq", 16'(irq_exp), 16'(irq));
            // Interrupt uses irq_en as it was before any write on this edge
            if (vdump == 9'(V_VIS) && hdump == 9'd0 && regs_m[REG_CTRL][CTRL_IRQ_EN] === 1'b1) begin
                irq_exp = 1;
            end else if (hdump == 9'd0) begin
                irq_exp = 0;
            end
            if (wb_o.ack) begin
                if (req_cnt != 2) begin
                    errors++;
                    $display("error %0t ack arrived %0d cycles after the strobe instead of 2",
                             $time, req_cnt);
                end
                model_rd = wb_i.adr[VRAM_AW] ? vram_m[wb_i.adr[VRAM_AW-1:0]]
                                             : regs_m[wb_i.adr[1:0]];
                if (wb_i.we && wb_i.adr[VRAM_AW]) begin
                    vram_m[wb_i.adr[VRAM_AW-1:0]] = wb_i.dat_w;
                end else if (wb_i.we) begin
                    regs_m[wb_i.adr[1:0]] = wb_i.dat_w;
                end else begin
                    check_val("dat_r", 16'(exp_dat), 16'(wb_o.dat_r));
                    check_val("dat_r", 16'(model_rd), 16'(wb_o.dat_r));
                end
                req_cnt = 0;
            end else if (wb_i.cyc && wb_i.stb) begin
                req_cnt++;
            end
            if (age < 3) begin
                age++;
            end
            h_d2 = h_d1;
            v_d2 = v_d1;
            h_d1 = hdump;
            v_d1 = vdump;
        end
    end

endmodule

`default_nettype wire

// ==== dv/gfx_tb.sv ====
/*
  Testbench top for the tile layer, small 64x24 visible geometry.
  ROM answers after 1 to 4 cycles, picked from a fixed seed.
  Whole VRAM is filled first, then the register table runs.
*/
`timescale 1ns/1ps
`default_nettype none

module gfx_tb
    import gfx_pkg::*;
();

    localparam int H_VIS   = 64;
    localparam int H_TOTAL = 256;
    localparam int V_VIS   = 24;
    localparam int V_TOTAL = 32;
    localparam int N_FILL  = 2**VRAM_AW;
    localparam int N_OPS   = 16;
    localparam longint LIMIT_CYC = 6 * H_TOTAL * V_TOTAL + (N_OPS + N_FILL + 1) * 10;

    typedef struct {
        bit         we;
        logic [10:0] adr;
        logic [7:0] dat;
        logic [7:0] exp;
    } op_t;

    // Fine scroll 5 with column wrap, vscroll wraps past row 255
    op_t ops [N_OPS] = '{
        '{1'b1, 11'h000, 8'hf5, 8'h00},
        '{1'b1, 11'h001, 8'hfa, 8'h00},
        '{1'b1, 11'h003, 8'h85, 8'h00},
        '{1'b1, 11'h002, 8'h21, 8'h00},
        '{1'b1, 11'h7ff, 8'h5a, 8'h00},
        '{1'b1, 11'h400, 8'h00, 8'h00},
        '{1'b1, 11'h41f, 8'hc3, 8'h00},
        '{1'b1, 11'h523, 8'h7e, 8'h00},
        '{1'b0, 11'h000, 8'h00, 8'hf5},
        '{1'b0, 11'h001, 8'h00, 8'hfa},
        '{1'b0, 11'h003, 8'h00, 8'h85},
        '{1'b0, 11'h002, 8'h00, 8'h21},
        '{1'b0, 11'h7ff, 8'h00, 8'h5a},
        '{1'b0, 11'h400, 8'h00, 8'h00},
        '{1'b0, 11'h41f, 8'h00, 8'hc3},
        '{1'b0, 11'h523, 8'h00, 8'h7e}
    };

    logic        clk;
    logic        rst;
    wb_req_t     wb_i;
    wb_rsp_t     wb_o;
    rom_req_t    rom;
    logic [15:0] rom_data;
    logic        rom_ok;
    logic [8:0]  hdump;
    logic [8:0]  vdump;
    logic        lhbl;
    logic        lvbl;
    logic [6:0]  pxl_out;
    logic        irq;
    logic        check_en;
    logic [7:0]  exp_dat;
    int          mon_err;
    int          pix_count;
    int          tb_err;
    int          asrt_err;
    integer      seed;

    gfx_top #(
        .H_VIS   (H_VIS),
        .H_TOTAL (H_TOTAL),
        .V_VIS   (V_VIS),
        .V_TOTAL (V_TOTAL)
    ) u_dut (
        .clk      (clk),
        .rst      (rst),
        .wb_i     (wb_i),
        .wb_o     (wb_o),
        .rom      (rom),
        .rom_data (rom_data),
        .rom_ok   (rom_ok),
        .hdump    (hdump),
        .vdump    (vdump),
        .lhbl     (lhbl),
        .lvbl     (lvbl),
        .pxl_out  (pxl_out),
        .irq      (irq)
    );

    gfx_monitor #(
        .H_VIS   (H_VIS),
        .H_TOTAL (H_TOTAL),
        .V_VIS   (V_VIS),
        .V_TOTAL (V_TOTAL)
    ) u_mon (
        .clk       (clk),
        .rst       (rst),
        .wb_i      (wb_i),
        .wb_o      (wb_o),
        .rom       (rom),
        .hdump     (hdump),
        .vdump     (vdump),
        .lhbl      (lhbl),
        .lvbl      (lvbl),
        .pxl_out   (pxl_out),
        .irq       (irq),
        .check_en  (check_en),
        .exp_dat   (exp_dat),
        .errors    (mon_err),
        .pix_count (pix_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic wb_xfer(input bit we, input logic [10:0] adr, input logic [7:0] dat,
                           input logic [7:0] exp);
        int n;
        n = 0;
        @(posedge clk);
        #1;
        exp_dat = exp;
        wb_i    = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat_w: dat};
        do begin
            @(negedge clk);
            n++;
        end while (!wb_o.ack && n < 20);
        if (!wb_o.ack) begin
            tb_err++;
            $display("error %0t no ack for the Wishbone transfer to %h", $time, adr);
        end
        @(posedge clk);
        #1;
        wb_i = '0;
    endtask

    task automatic wait_frame_start();
        do begin
            @(negedge clk);
        end while (!(hdump == 9'd0 && vdump == 9'd0));
    endtask

    // ROM model, one request at a time
    initial begin
        int lat;
        forever begin
            @(posedge clk);
            #1;
            if (rom.cs) begin
                lat = 1 + ($unsigned($random(seed)) % 4);
                for (int i = 1; i < lat; i++) begin
                    @(posedge clk);
                    #1;
                end
                rom_data = u_mon.rom_word(rom.addr);
                rom_ok   = 1'b1;
                @(posedge clk);
                #1;
                rom_ok = 1'b0;
            end
        end
    end

    initial begin
        #(LIMIT_CYC * 10);
        $display("error watchdog expired before the test finished");
        $display("sim failed");
        $finish;
    end

    initial begin
        seed     = 32'ha55fd898;
        rst      = 1'b1;
        wb_i     = '0;
        rom_data = '0;
        rom_ok   = 1'b0;
        check_en = 1'b0;
        exp_dat  = '0;
        tb_err   = 0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int a = 0; a < N_FILL; a++) begin
            wb_xfer(1'b1, 11'h400 | 11'(a), 8'((a * 13) ^ (a >> 2)), 8'h00);
        end
        for (int i = 0; i < N_OPS; i++) begin
            wb_xfer(ops[i].we, ops[i].adr, ops[i].dat, ops[i].exp);
        end
        // Line 0 of the next frame is fetched after this point
        do begin
            @(negedge clk);
        end while (lvbl);
        check_en = 1'b1;
        repeat (3) wait_frame_start();
        wb_xfer(1'b1, 11'h002, 8'h20, 8'h00);
        repeat (2) wait_frame_start();
        if (pix_count == 0) begin
            tb_err++;
            $display("error pixel comparison never started");
        end
        asrt_err = u_dut.u_fetch.u_fetch_chk.fail_cnt + u_dut.u_cpu_port.u_port_chk.fail_cnt;
        $display("errors: monitor %0d, assertions %0d, testbench %0d, pixels checked %0d",
                 mon_err, asrt_err, tb_err, pix_count);
        if (mon_err == 0 && asrt_err == 0 && tb_err == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
design/gfx_pkg.sv
design/gfx_dpram.sv
design/video_timer.sv
design/gfx_cpu_port.sv
design/tile_fetch.sv
design/gfx_mixer.sv
design/gfx_top.sv
dv/gfx_checker.sv
dv/gfx_monitor.sv
dv/gfx_tb.sv
